//--- aes_cfg.svh
`ifndef AES_CFG_SVH
`define AES_CFG_SVH

// cipher rounds for a 128-bit key
`define AES_ROUNDS 10

// word address width of the bus port
`define AES_WB_ADR_W 4

// register map, word addresses
`define AES_REG_KEY0 0   // key words 0..3
`define AES_REG_DIN0 4   // plaintext words 0..3
`define AES_REG_CTRL 8   // bit 0 = start
`define AES_REG_STAT 9   // bit 0 = busy, bit 1 = done
`define AES_REG_DOUT0 12 // ciphertext words 0..3

`endif

//--- aes_pkg.sv
package aes_pkg;

  // one state or key block, FIPS-197 byte 0 in bits 127:120
  typedef logic [127:0] block_t;

  // one column or bus word
  typedef logic [31:0] word_t;

  // one S-box operand
  typedef logic [7:0] byte_t;

  // round number 0..10
  typedef logic [3:0] rnd_t;

  // core sequencing
  typedef enum logic {
    IDLE,
    RUN
  } core_state_e;

endpackage

//--- aes_sbox.sv
`timescale 1ns/100ps

module aes_sbox
(
  input  aes_pkg::byte_t in_byte,
  output aes_pkg::byte_t out_byte
);

  // GF(2^8) product modulo x^8 + x^4 + x^3 + x + 1
  function automatic aes_pkg::byte_t gf_mul(input aes_pkg::byte_t a, input aes_pkg::byte_t b);
    aes_pkg::byte_t p;
    aes_pkg::byte_t aa;
    p  = '0;
    aa = a;
    for (int i = 0; i < 8; i++)
    begin
      if (b[i])
        p = p ^ aa;
      aa = {aa[6:0], 1'b0} ^ (aa[7] ? 8'h1b : 8'h00); // xtime
    end
    return p;
  endfunction

  aes_pkg::byte_t sq [1:7]; // x^2, x^4 .. x^128
  aes_pkg::byte_t inv;      // x^254, zero stays zero

  always_comb
  begin
    sq[1] = gf_mul(in_byte, in_byte);
    for (int k = 2; k <= 7; k++)
      sq[k] = gf_mul(sq[k-1], sq[k-1]);
  end

  // x^254 = x^2 * x^4 * ... * x^128
  always_comb
  begin
    inv = sq[1];
    for (int k = 2; k <= 7; k++)
      inv = gf_mul(inv, sq[k]);
  end

  // affine transform, b ^ rotl1 ^ rotl2 ^ rotl3 ^ rotl4 ^ 63
  assign out_byte = inv
                  ^ {inv[6:0], inv[7]}
                  ^ {inv[5:0], inv[7:6]}
                  ^ {inv[4:0], inv[7:5]}
                  ^ {inv[3:0], inv[7:4]}
                  ^ 8'h63;

endmodule

//--- aes_key_expand.sv
`timescale 1ns/100ps

module aes_key_expand
(
  input  logic           CLK,
  input  logic           RST,
  input  logic           load,      // take the cipher key
  input  logic           step,      // advance to the next round key
  input  aes_pkg::block_t key,
  input  aes_pkg::rnd_t   rnd,       // round whose key is produced
  output aes_pkg::block_t round_key
);

  aes_pkg::block_t key_q; // current round key
  aes_pkg::word_t  w3_rot; // RotWord of the last word
  aes_pkg::word_t  w3_sub; // after the S-boxes
  aes_pkg::word_t  w3_g;   // g-function result
  aes_pkg::byte_t  rcon;
  aes_pkg::word_t  w0;
  aes_pkg::word_t  w1;
  aes_pkg::word_t  w2;
  aes_pkg::word_t  w3;

  always_ff @(posedge CLK or negedge RST)
  begin
    if (!RST)
      key_q <= '0;
    else if (load)
      key_q <= key;
    else if (step)
      key_q <= round_key;
  end

  assign w3_rot = {key_q[23:16], key_q[15:8], key_q[7:0], key_q[31:24]};

  genvar g;
  for (g = 0; g < 4; g++)
  begin : g_sbox
    aes_sbox u_sbox
    (
      .in_byte  (w3_rot[8*g +: 8]),
      .out_byte (w3_sub[8*g +: 8])
    );
  end

  always_comb
  begin
    case (rnd)
      4'd1:    rcon = 8'h01;
      4'd2:    rcon = 8'h02;
      4'd3:    rcon = 8'h04;
      4'd4:    rcon = 8'h08;
      4'd5:    rcon = 8'h10;
      4'd6:    rcon = 8'h20;
      4'd7:    rcon = 8'h40;
      4'd8:    rcon = 8'h80;
      4'd9:    rcon = 8'h1b;
      4'd10:   rcon = 8'h36;
      default: rcon = 8'h00; // outside the schedule
    endcase
  end

  assign w3_g = {w3_sub[31:24] ^ rcon, w3_sub[23:0]};

  // chained word xor from left to right
  assign w0 = key_q[127:96] ^ w3_g;
  assign w1 = key_q[95:64]  ^ w0;
  assign w2 = key_q[63:32]  ^ w1;
  assign w3 = key_q[31:0]   ^ w2;

  assign round_key = {w0, w1, w2, w3};

endmodule

//--- aes_round.sv
`timescale 1ns/100ps

module aes_round
(
  input  aes_pkg::block_t state_in,
  input  aes_pkg::block_t round_key,
  input  logic            last,      // final round, no MixColumns
  output aes_pkg::block_t state_out
);

  // multiply by x in GF(2^8)
  function automatic aes_pkg::byte_t xt(input aes_pkg::byte_t a);
    return {a[6:0], 1'b0} ^ (a[7] ? 8'h1b : 8'h00);
  endfunction

  // one MixColumns column, row 0 in the top byte
  function automatic aes_pkg::word_t mix_col(input aes_pkg::word_t col);
    aes_pkg::byte_t a0;
    aes_pkg::byte_t a1;
    aes_pkg::byte_t a2;
    aes_pkg::byte_t a3;
    a0 = col[31:24];
    a1 = col[23:16];
    a2 = col[15:8];
    a3 = col[7:0];
    return {xt(a0) ^ xt(a1) ^ a1 ^ a2 ^ a3,
            a0 ^ xt(a1) ^ xt(a2) ^ a2 ^ a3,
            a0 ^ a1 ^ xt(a2) ^ xt(a3) ^ a3,
            xt(a0) ^ a0 ^ a1 ^ a2 ^ xt(a3)};
  endfunction

  aes_pkg::block_t sub; // after SubBytes
  aes_pkg::block_t shf; // after ShiftRows
  aes_pkg::block_t mix; // after MixColumns

  genvar g;
  genvar r;
  genvar c;

  // byte k sits at bits 127-8k, row k%4, column k/4
  for (g = 0; g < 16; g++)
  begin : g_sub
    aes_sbox u_sbox
    (
      .in_byte  (state_in[127-8*g -: 8]),
      .out_byte (sub[127-8*g -: 8])
    );
  end

  // row r rotates left by r columns
  for (r = 0; r < 4; r++)
  begin : g_row
    for (c = 0; c < 4; c++)
    begin : g_col
      assign shf[127-8*(r+4*c) -: 8] = sub[127-8*(r+4*((c+r)%4)) -: 8];
    end
  end

  for (c = 0; c < 4; c++)
  begin : g_mix
    assign mix[127-32*c -: 32] = mix_col(shf[127-32*c -: 32]);
  end

  assign state_out = (last ? shf : mix) ^ round_key;

endmodule

//--- aes_core.sv
`timescale 1ns/100ps

`include "aes_cfg.svh"

module aes_core
(
  input  logic            CLK,
  input  logic            RST,
  input  logic            start,     // one-cycle request from the bus side
  input  aes_pkg::block_t key,
  input  aes_pkg::block_t din,
  output logic            busy,
  output logic            done,      // sticky until the next start
  output aes_pkg::block_t dout,
  output logic            load,      // key expander takes the cipher key
  output logic            step,      // key expander advances
  output aes_pkg::rnd_t   rnd,
  input  aes_pkg::block_t round_key
);

  aes_pkg::core_state_e cur_state;
  aes_pkg::block_t      blk;       // cipher state
  aes_pkg::block_t      round_out;
  logic                 last;

  assign busy = (cur_state == aes_pkg::RUN);
  assign load = (cur_state == aes_pkg::IDLE) && start; // starts ignored while running
  assign step = (cur_state == aes_pkg::RUN);
  assign last = (rnd == aes_pkg::rnd_t'(`AES_ROUNDS));

  aes_round u_round
  (
    .state_in  (blk),
    .round_key (round_key),
    .last      (last),
    .state_out (round_out)
  );

  // initial AddRoundKey on load, one round per step
  always_ff @(posedge CLK)
  begin
    if (load)
      blk <= din ^ key;
    else if (step)
      blk <= round_out;
  end

  always_ff @(posedge CLK or negedge RST)
  begin
    if (!RST)
    begin
      cur_state <= aes_pkg::IDLE;
      rnd       <= '0;
      done      <= 1'b0;
      dout      <= '0;
    end
    else
    begin
      case (cur_state)
        aes_pkg::IDLE:
        begin
          if (start)
          begin
            cur_state <= aes_pkg::RUN;
            rnd       <= 4'd1;
            done      <= 1'b0;
          end
        end
        aes_pkg::RUN:
        begin
          if (last)
          begin
            cur_state <= aes_pkg::IDLE;
            rnd       <= '0;
            done      <= 1'b1;
            dout      <= round_out; // ciphertext held until the next run ends
          end
          else
            rnd <= rnd + 4'd1;
        end
        default:
          cur_state <= aes_pkg::IDLE;
      endcase
    end
  end

endmodule

//--- aes_wb_slave.sv
`timescale 1ns/100ps

`include "aes_cfg.svh"

module aes_wb_slave
(
  input  logic                     CLK,
  input  logic                     RST,
  input  logic                     wb_cyc,
  input  logic                     wb_stb,
  input  logic                     wb_we,
  input  logic [`AES_WB_ADR_W-1:0] wb_adr,
  input  aes_pkg::word_t           wb_dat_w,
  output aes_pkg::word_t           wb_dat_r,
  output logic                     wb_ack,
  output logic                     start,
  output aes_pkg::block_t          key,
  output aes_pkg::block_t          din,
  input  logic                     busy,
  input  logic                     done,
  input  aes_pkg::block_t          dout
);

  localparam logic [`AES_WB_ADR_W-1:0] ADR_KEY0 = `AES_REG_KEY0;
  localparam logic [`AES_WB_ADR_W-1:0] ADR_DIN0 = `AES_REG_DIN0;
  localparam logic [`AES_WB_ADR_W-1:0] ADR_CTRL = `AES_REG_CTRL;
  localparam logic [`AES_WB_ADR_W-1:0] ADR_STAT = `AES_REG_STAT;
  localparam logic [`AES_WB_ADR_W-1:0] ADR_DOUT0 = `AES_REG_DOUT0;
  localparam logic [`AES_WB_ADR_W-1:0] BLK_MASK = ~`AES_WB_ADR_W'(3); // four-word groups

  logic       acc;     // new request not yet acked
  logic       sel_key;
  logic       sel_din;
  logic       sel_dout;
  logic [1:0] idx;     // word within a block

  // word i of a block is bits 127-32i down to 96-32i
  function automatic aes_pkg::word_t pick(input aes_pkg::block_t b, input logic [1:0] i);
    return b[(3 - i)*32 +: 32];
  endfunction

  assign acc      = wb_cyc && wb_stb && !wb_ack;
  assign idx      = wb_adr[1:0];
  assign sel_key  = (wb_adr & BLK_MASK) == ADR_KEY0;
  assign sel_din  = (wb_adr & BLK_MASK) == ADR_DIN0;
  assign sel_dout = (wb_adr & BLK_MASK) == ADR_DOUT0;

  // single-cycle ack and a start pulse only when the core is idle
  always_ff @(posedge CLK or negedge RST)
  begin
    if (!RST)
    begin
      wb_ack <= 1'b0;
      start  <= 1'b0;
    end
    else
    begin
      wb_ack <= acc;
      start  <= acc && wb_we && (wb_adr == ADR_CTRL) && wb_dat_w[0] && !busy;
    end
  end

  // key and plaintext words visible on the ack cycle
  always_ff @(posedge CLK)
  begin
    for (int i = 0; i < 4; i++)
    begin
      if (acc && wb_we && sel_key && (idx == i))
        key[127-32*i -: 32] <= wb_dat_w;
      if (acc && wb_we && sel_din && (idx == i))
        din[127-32*i -: 32] <= wb_dat_w;
    end
  end

  always_comb
  begin
    if (sel_key)
      wb_dat_r = pick(key, idx);
    else if (sel_din)
      wb_dat_r = pick(din, idx);
    else if (sel_dout)
      wb_dat_r = pick(dout, idx);
    else if (wb_adr == ADR_STAT)
      wb_dat_r = {30'd0, done, busy};
    else
      wb_dat_r = '0; // CTRL and unmapped
  end

endmodule

//--- aes_wb_top.sv
`timescale 1ns/100ps

`include "aes_cfg.svh"

module aes_wb_top
(
  input  logic                     CLK,
  input  logic                     RST,
  input  logic                     wb_cyc,
  input  logic                     wb_stb,
  input  logic                     wb_we,
  input  logic [`AES_WB_ADR_W-1:0] wb_adr,
  input  aes_pkg::word_t           wb_dat_w,
  output aes_pkg::word_t           wb_dat_r,
  output logic                     wb_ack
);

  logic            start;
  logic            busy;
  logic            done;
  logic            load;
  logic            step;
  aes_pkg::rnd_t   rnd;
  aes_pkg::block_t key;
  aes_pkg::block_t din;
  aes_pkg::block_t dout;
  aes_pkg::block_t round_key;

  aes_wb_slave u_slave
  (
    .CLK      (CLK),
    .RST      (RST),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_we    (wb_we),
    .wb_adr   (wb_adr),
    .wb_dat_w (wb_dat_w),
    .wb_dat_r (wb_dat_r),
    .wb_ack   (wb_ack),
    .start    (start),
    .key      (key),
    .din      (din),
    .busy     (busy),
    .done     (done),
    .dout     (dout)
  );

  aes_core u_core
  (
    .CLK       (CLK),
    .RST       (RST),
    .start     (start),
    .key       (key),
    .din       (din),
    .busy      (busy),
    .done      (done),
    .dout      (dout),
    .load      (load),
    .step      (step),
    .rnd       (rnd),
    .round_key (round_key)
  );

  aes_key_expand u_kexp
  (
    .CLK       (CLK),
    .RST       (RST),
    .load      (load),
    .step      (step),
    .key       (key),
    .rnd       (rnd),
    .round_key (round_key)
  );

endmodule

//--- tb_aes_wb_top.sv
`timescale 1ns/100ps

`include "aes_cfg.svh"

module tb_aes_wb_top;

  localparam int CLK_PERIOD  = 20;
  localparam int NUM_TESTS   = 5;
  localparam int TEST_CYCLES = 400;
  localparam int ACK_LIMIT   = 16; // cycles to wait for wb_ack
  localparam int POLL_LIMIT  = 40; // status reads before giving up

  // FIPS-197 appendix C.1
  localparam aes_pkg::block_t C1_KEY = 128'h000102030405060708090a0b0c0d0e0f;
  localparam aes_pkg::block_t C1_PT  = 128'h00112233445566778899aabbccddeeff;
  localparam aes_pkg::block_t C1_CT  = 128'h69c4e0d86a7b0430d8cdb78070b4c55a;
  // FIPS-197 appendix B
  localparam aes_pkg::block_t B_KEY  = 128'h2b7e151628aed2a6abf7158809cf4f3c;
  localparam aes_pkg::block_t B_PT   = 128'h3243f6a8885a308d313198a2e0370734;
  localparam aes_pkg::block_t B_CT   = 128'h3925841d02dc09fbdc118597196a0b32;
  // all-zero key and plaintext
  localparam aes_pkg::block_t Z_CT   = 128'h66e94bd4ef8a2c3b884cfa59ca342b2e;

  logic                     CLK;
  logic                     RST;
  logic                     wb_cyc;
  logic                     wb_stb;
  logic                     wb_we;
  logic [`AES_WB_ADR_W-1:0] wb_adr;
  aes_pkg::word_t           wb_dat_w;
  aes_pkg::word_t           wb_dat_r;
  logic                     wb_ack;

  int errors;
  int errors_at_start; // error count when the current test began
  int tests_passed;
  int tests_failed;

  aes_wb_top u_dut
  (
    .CLK      (CLK),
    .RST      (RST),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_we    (wb_we),
    .wb_adr   (wb_adr),
    .wb_dat_w (wb_dat_w),
    .wb_dat_r (wb_dat_r),
    .wb_ack   (wb_ack)
  );

  initial
  begin
    CLK = 1'b0;
    forever #(CLK_PERIOD / 2) CLK = ~CLK;
  end

  initial
  begin
    #(NUM_TESTS * TEST_CYCLES * CLK_PERIOD);
    $display("watchdog: the run timed out before all tests finished");
    $display("FAIL: see errors above");
    $finish;
  end

  // ack is a single-cycle pulse
  ack_one_cycle: assert property (@(posedge CLK) disable iff (!RST)
                                  !(wb_ack && $past(wb_ack)))
  else
  begin
    $display("[ERROR] t=%0t wb_ack stayed high for two cycles in a row", $time);
    errors++;
  end

  // starts on a falling edge and returns on the falling edge of the ack cycle
  task automatic bus_cycle(input logic we, input int adr, input aes_pkg::word_t wdata,
                           output aes_pkg::word_t rdata);
    int n;
    n        = 0;
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = we;
    wb_adr   = `AES_WB_ADR_W'(adr);
    wb_dat_w = wdata;
    do
    begin
      @(negedge CLK);
      n++;
    end
    while (!wb_ack && n < ACK_LIMIT);
    if (!wb_ack)
    begin
      $display("bus access to address %0d was never acknowledged", adr);
      errors++;
    end
    rdata  = wb_dat_r; // stable away from the rising edge
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
  endtask

  task automatic wb_write(input int adr, input aes_pkg::word_t data);
    aes_pkg::word_t unused;
    bus_cycle(1'b1, adr, data, unused);
  endtask

  task automatic wb_read(input int adr, output aes_pkg::word_t data);
    bus_cycle(1'b0, adr, 32'd0, data);
  endtask

  task automatic check_word(input string name, input aes_pkg::word_t got,
                            input aes_pkg::word_t exp);
    assert (got == exp)
    else
    begin
      $display("[ERROR] t=%0t %s: got %08h, expected %08h", $time, name, got, exp);
      errors++;
    end
  endtask

  // word i sits at bits 127-32i down to 96-32i
  task automatic write_block(input int base, input aes_pkg::block_t blk);
    for (int i = 0; i < 4; i++)
      wb_write(base + i, blk[127-32*i -: 32]);
  endtask

  task automatic check_block(input string name, input int base, input aes_pkg::block_t exp);
    aes_pkg::word_t rd;
    for (int i = 0; i < 4; i++)
    begin
      wb_read(base + i, rd);
      check_word($sformatf("%s%0d", name, i), rd, exp[127-32*i -: 32]);
    end
  endtask

  task automatic check_status(input aes_pkg::word_t exp);
    aes_pkg::word_t rd;
    wb_read(`AES_REG_STAT, rd);
    check_word("STAT", rd, exp);
  endtask

  task automatic wait_done();
    aes_pkg::word_t rd;
    int             n;
    n = 0;
    do
    begin
      wb_read(`AES_REG_STAT, rd);
      n++;
    end
    while (!rd[1] && n < POLL_LIMIT);
    if (!rd[1])
    begin
      $display("status never showed done after %0d reads", n);
      errors++;
    end
  endtask

  task automatic run_vector(input aes_pkg::block_t key, input aes_pkg::block_t pt);
    write_block(`AES_REG_KEY0, key);
    write_block(`AES_REG_DIN0, pt);
    wb_write(`AES_REG_CTRL, 32'h1);
    wait_done();
  endtask

  task automatic begin_test();
    errors_at_start = errors;
  endtask

  task automatic end_test(input int num, input string name);
    if (errors == errors_at_start)
    begin
      tests_passed++;
      $display("test %0d %s: ok", num, name);
    end
    else
    begin
      tests_failed++;
      $display("test %0d %s: %0d errors", num, name, errors - errors_at_start);
    end
  endtask

  initial
  begin
    RST             = 1'b0;
    wb_cyc          = 1'b0;
    wb_stb          = 1'b0;
    wb_we           = 1'b0;
    wb_adr          = '0;
    wb_dat_w        = '0;
    errors          = 0;
    errors_at_start = 0;
    tests_passed    = 0;
    tests_failed    = 0;
    repeat (2) @(posedge CLK); // two rising edges in reset
    @(negedge CLK);
    RST = 1'b1;

    begin_test();
    check_status(32'h0);
    check_block("DOUT", `AES_REG_DOUT0, '0);
    end_test(1, "reset values");

    begin_test();
    run_vector(C1_KEY, C1_PT);
    check_block("DOUT", `AES_REG_DOUT0, C1_CT);
    check_status(32'h2); // done and not busy
    end_test(2, "appendix C.1 vector");

    begin_test();
    run_vector(B_KEY, B_PT);
    check_block("DOUT", `AES_REG_DOUT0, B_CT);
    check_block("KEY", `AES_REG_KEY0, B_KEY);
    check_block("DIN", `AES_REG_DIN0, B_PT);
    end_test(3, "appendix B vector and readback");

    begin_test();
    write_block(`AES_REG_KEY0, C1_KEY);
    write_block(`AES_REG_DIN0, C1_PT);
    wb_write(`AES_REG_CTRL, 32'h1);
    check_status(32'h1);                          // running
    wb_write(`AES_REG_DIN0, B_PT[127:96]);        // new plaintext mid-run
    wb_write(`AES_REG_DIN0 + 1, B_PT[95:64]);
    wb_write(`AES_REG_CTRL, 32'h1);               // dropped as the core is still busy
    wait_done();
    check_block("DOUT", `AES_REG_DOUT0, C1_CT);
    check_status(32'h2);
    end_test(4, "start while busy");

    begin_test();
    write_block(`AES_REG_KEY0, '0);
    write_block(`AES_REG_DIN0, '0);
    wb_write(`AES_REG_CTRL, 32'h1);
    check_status(32'h1); // done cleared by the new start
    wait_done();
    check_status(32'h2);
    check_block("DOUT", `AES_REG_DOUT0, Z_CT);
    end_test(5, "back-to-back zero vector");

    $display("tests passed=%0d failed=%0d, errors=%0d", tests_passed, tests_failed, errors);
    if (tests_failed == 0 && errors == 0)
      $display("PASS: all tests");
    else
      $display("FAIL: see errors above");
    $finish;
  end

endmodule

//--- aes_wb_top.f
+incdir+.
aes_pkg.sv
aes_sbox.sv
aes_key_expand.sv
aes_round.sv
aes_core.sv
aes_wb_slave.sv
aes_wb_top.sv
tb_aes_wb_top.sv

//--- run_sim.sh
#!/bin/sh
# build and run the AES Wishbone testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  -f aes_wb_top.f --top-module tb_aes_wb_top -o tb_aes_wb_top

./obj_dir/tb_aes_wb_top > sim.log 2>&1
cat sim.log

if grep -q "FAIL: see errors above" sim.log; then
  echo "simulation failed"
  exit 1
fi
echo "simulation passed"
